// File: hw/usbRx_defs.svh
`ifndef USBRX_DEFS_SVH
`define USBRX_DEFS_SVH

// Full speed bit time in clk48 cycles
`define USB_BIT_CYCLES 4

// Consecutive ones before the transmitter inserts a zero
`define USB_MAX_ONES 6

// Remainder left in the CRC5 register after a good token
// Register shifts MSB first over data and CRC bits
`define USB_CRC5_RESIDUE 5'b01100

// Remainder left in the CRC16 register after a good data packet
`define USB_CRC16_RESIDUE 16'h800D

`endif

// File: hw/sieLinePkg.sv
`default_nettype none

package sieLinePkg;

    // Sampled differential pair as {P, N}
    typedef enum logic [1:0] {
        SE0 = 2'b00,
        K   = 2'b01,
        J   = 2'b10,
        SE1 = 2'b11
    } lineSymbol;

    // One decoded bit slot from the line frontend
    typedef struct packed {
        logic strobe;
        logic value;
        logic stuffed;
        logic stuffError;
        logic lineError;
        logic eop;
    } rxBit;

    // Receive controller states
    typedef enum logic [1:0] {
        waitSync,
        getPid,
        waitEop,
        rstPhase
    } rxState;

    // Tail of the sync field in the upper nibble of the deserializer
    localparam logic [3:0] syncPattern = 4'b1000;

endpackage

`default_nettype wire

// File: hw/usbPacketPkg.sv
`default_nettype none

package usbPacketPkg;

    // Packet identifiers as sent on the wire
    typedef enum logic [3:0] {
        pidReserved = 4'b0000,
        pidOut      = 4'b0001,
        pidAck      = 4'b0010,
        pidData0    = 4'b0011,
        pidPing     = 4'b0100,
        pidSof      = 4'b0101,
        pidNyet     = 4'b0110,
        pidData2    = 4'b0111,
        pidSplit    = 4'b1000,
        pidIn       = 4'b1001,
        pidNak      = 4'b1010,
        pidData1    = 4'b1011,
        pidPre      = 4'b1100,
        pidSetup    = 4'b1101,
        pidStall    = 4'b1110,
        pidMdata    = 4'b1111
    } pidCode;

    // Low PID bits of every data packet, which carry a CRC16
    localparam logic [1:0] dataPidMask = 2'b11;

    // PID byte split into type and inverted check nibble
    typedef struct packed {
        logic [3:0] pidCheck;
        pidCode     pidType;
    } pidFields;

    // Received byte seen either as raw data or as a PID
    typedef union packed {
        logic [7:0] raw;
        pidFields   pid;
    } pidOrByte;

    // Byte with its tags on the way to the backend
    typedef struct packed {
        logic [7:0] data;
        logic       isLast;
        logic       isData;
    } rxByte;

endpackage

`default_nettype wire

// File: hw/rxLineFrontend.sv
`timescale 1ns/10ps
`default_nettype none

`include "usbRx_defs.svh"

module rxLineFrontend (
    input  logic              clk48,
    input  logic              rxRST,
    input  logic              dataInP,
    input  logic              dataInN,
    output sieLinePkg::rxBit  lineBit
);

    logic [1:0] pSync;
    logic [1:0] nSync;
    sieLinePkg::lineSymbol lineSym;
    sieLinePkg::lineSymbol prevSym;
    sieLinePkg::lineSymbol lastSym;
    logic [3:0] phase;
    logic [2:0] onesCount;
    logic lineEdge;
    logic bitTick;
    logic isDataSym;
    logic isEop;
    logic nrziValue;
    logic stuffSlot;

    // Two flop synchronizer per line that resets to idle J
    always_ff @(posedge clk48) begin
        if (rxRST) begin
            pSync <= 2'b11;
            nSync <= 2'b00;
        end else begin
            pSync <= {pSync[0], dataInP};
            nSync <= {nSync[0], dataInN};
        end
    end

    assign lineSym = sieLinePkg::lineSymbol'({pSync[1], nSync[1]});
    assign lineEdge = (lineSym != prevSym);

    // ==================================================================
    // Bit clock recovery
    // ==================================================================

    // Phase restarts on every edge; tick lands two cycles later
    always_ff @(posedge clk48) begin
        if (rxRST) begin
            prevSym <= sieLinePkg::J;
            phase   <= '0;
        end else begin
            prevSym <= lineSym;
            if (lineEdge || phase == 4'(`USB_BIT_CYCLES - 1))
                phase <= '0;
            else
                phase <= phase + 4'd1;
        end
    end

    assign bitTick = (phase == 4'd1) && !lineEdge;

    // ==================================================================
    // NRZI decode and unstuffing
    // ==================================================================
    assign isDataSym = (lineSym == sieLinePkg::J) || (lineSym == sieLinePkg::K);
    assign isEop     = (lineSym == sieLinePkg::J) && (lastSym == sieLinePkg::SE0);
    // No change means one
    assign nrziValue = (lineSym == lastSym);
    assign stuffSlot = (onesCount == 3'(`USB_MAX_ONES));

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            lastSym   <= sieLinePkg::J;
            onesCount <= '0;
            lineBit   <= '0;
        end else if (bitTick) begin
            lastSym            <= lineSym;
            // J after SE0 closes the packet and carries no data
            lineBit.strobe     <= isDataSym && !isEop;
            lineBit.value      <= nrziValue;
            lineBit.stuffed    <= isDataSym && stuffSlot;
            lineBit.stuffError <= isDataSym && stuffSlot && nrziValue;
            lineBit.lineError  <= (lineSym == sieLinePkg::SE1);
            lineBit.eop        <= isEop;
            // Count stays saturated while ones keep coming
            if (!isDataSym || isEop || !nrziValue)
                onesCount <= '0;
            else if (!stuffSlot)
                onesCount <= onesCount + 3'd1;
        end else begin
            lineBit <= '0;
        end
    end

    // At most one bit slot per bit time
    assert property (@(posedge clk48) disable iff (rxRST)
        lineBit.strobe |=> !lineBit.strobe)
        else $error("bit strobe on two consecutive cycles");

endmodule

`default_nettype wire

// File: hw/rxCrcCheck.sv
`timescale 1ns/10ps
`default_nettype none

`include "usbRx_defs.svh"

module rxCrcCheck (
    input  logic             clk48,
    input  logic             rxRST,
    input  sieLinePkg::rxBit lineBit,
    input  logic             crcReset,
    input  logic             useCrc16,
    output logic             crcValid
);

    logic [4:0]  crc5;
    logic [15:0] crc16;
    logic        mode16;
    logic        fb5;
    logic        fb16;

    // Feedback taps of registers shifted MSB first
    assign fb5  = lineBit.value ^ crc5[4];
    assign fb16 = lineBit.value ^ crc16[15];

    always_ff @(posedge clk48) begin
        if (rxRST || crcReset) begin
            crc5  <= '1;
            crc16 <= '1;
        end else if (lineBit.strobe && !lineBit.stuffed) begin
            // x^5 + x^2 + 1
            crc5  <= {crc5[3:0], 1'b0} ^ (fb5 ? 5'b00101 : 5'b00000);
            // x^16 + x^15 + x^2 + 1
            crc16 <= {crc16[14:0], 1'b0} ^ (fb16 ? 16'h8005 : 16'h0000);
        end
    end

    // Mode is captured with the start of the payload
    always_ff @(posedge clk48) begin
        if (rxRST)
            mode16 <= 1'b0;
        else if (crcReset)
            mode16 <= useCrc16;
    end

    // Residue check on the selected register
    assign crcValid = mode16 ? (crc16 == `USB_CRC16_RESIDUE)
                             : (crc5 == `USB_CRC5_RESIDUE);

    // Controller must restart the CRC between bit slots
    assert property (@(posedge clk48) disable iff (rxRST)
        !(crcReset && lineBit.strobe))
        else $error("CRC restart collides with a bit strobe");

endmodule

`default_nettype wire

// File: hw/usbRx.sv
`timescale 1ns/10ps
`default_nettype none

`include "usbRx_defs.svh"

module usbRx (
    input  logic             clk48,
    input  logic             rxRST,
    input  sieLinePkg::rxBit lineBit,
    input  logic             crcValid,
    output logic             crcReset,
    output logic             useCrc16,
    input  logic             rxAcceptNewData,
    output logic [7:0]       rxData,
    output logic             rxIsLastByte,
    output logic             rxDataValid,
    output logic             keepPacket
);

    logic [7:0] shiftReg;
    logic [2:0] bitCount;
    logic newBit;
    logic byteDone;
    logic dataBit;
    logic syncSeen;
    logic pidValid;
    logic inPacket;
    logic lineFault;
    logic pipeShift;
    logic drainTick;
    logic [1:0] drainLeft;
    logic [3:0] drainTimer;
    logic needCrc16;
    logic lastCrcOk;
    logic dropPacket;
    logic lostByte;
    sieLinePkg::rxState state;
    usbPacketPkg::pidOrByte pidView;
    usbPacketPkg::rxByte newByte;
    usbPacketPkg::rxByte stage0;
    usbPacketPkg::rxByte stage1;
    usbPacketPkg::rxByte stage2;

    // ==================================================================
    // Deserializer and sync
    // ==================================================================
    assign dataBit = lineBit.strobe && !lineBit.stuffed;

    // LSB first with the newest bit entering at the top
    // Idle line shifts in ones, so reset to ones as well
    always_ff @(posedge clk48) begin
        if (rxRST)
            shiftReg <= '1;
        else if (dataBit)
            shiftReg <= {lineBit.value, shiftReg[7:1]};
    end

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            bitCount <= '0;
            newBit   <= 1'b0;
            byteDone <= 1'b0;
        end else begin
            newBit   <= dataBit;
            byteDone <= dataBit && (bitCount == 3'd7);
            // Align byte boundary to the end of sync
            if (syncSeen)
                bitCount <= '0;
            else if (dataBit)
                bitCount <= bitCount + 3'd1;
        end
    end

    assign syncSeen = (state == sieLinePkg::waitSync) && newBit
                      && (shiftReg[7:4] == sieLinePkg::syncPattern);

    // PID check and CRC mode straight from the assembled byte
    assign pidView.raw = shiftReg;
    assign pidValid    = (pidView.pid.pidCheck == ~pidView.pid.pidType);
    assign useCrc16    = (pidView.pid.pidType[1:0] == usbPacketPkg::dataPidMask);
    // Restart CRC right after the PID and before the first payload bit
    assign crcReset    = (state == sieLinePkg::getPid) && byteDone;

    // ==================================================================
    // Packet state machine
    // ==================================================================
    assign inPacket  = (state == sieLinePkg::getPid) || (state == sieLinePkg::waitEop);
    assign lineFault = lineBit.stuffError || lineBit.lineError;

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            state      <= sieLinePkg::waitSync;
            needCrc16  <= 1'b0;
            lastCrcOk  <= 1'b1;
            dropPacket <= 1'b0;
        end else begin
            unique case (state)
                sieLinePkg::waitSync: begin
                    // Drop flag of the previous packet holds until here
                    if (syncSeen) begin
                        state      <= sieLinePkg::getPid;
                        dropPacket <= 1'b0;
                        lastCrcOk  <= 1'b1;
                    end
                end
                sieLinePkg::getPid: begin
                    if (lineBit.eop) begin
                        // Truncated packet
                        state      <= sieLinePkg::rstPhase;
                        dropPacket <= 1'b1;
                    end else if (byteDone) begin
                        state      <= sieLinePkg::waitEop;
                        needCrc16  <= useCrc16;
                        dropPacket <= dropPacket || lineFault || !pidValid;
                    end else begin
                        dropPacket <= dropPacket || lineFault;
                    end
                end
                sieLinePkg::waitEop: begin
                    if (lineBit.eop) begin
                        state      <= sieLinePkg::rstPhase;
                        dropPacket <= dropPacket || !lastCrcOk;
                    end else begin
                        dropPacket <= dropPacket || lineFault;
                        // CRC state as of the end of the latest byte
                        if (byteDone)
                            lastCrcOk <= crcValid;
                    end
                end
                sieLinePkg::rstPhase: state <= sieLinePkg::waitSync;
                default: state <= sieLinePkg::waitSync;
            endcase
        end
    end

    // ==================================================================
    // Delay pipeline and drain after end of packet
    // ==================================================================
    assign drainTick = (drainLeft != 2'd0) && (drainTimer == 4'(`USB_BIT_CYCLES - 1));
    assign pipeShift = (inPacket && byteDone) || drainTick;

    always_comb begin
        newByte        = '0;
        newByte.data   = shiftReg;
        newByte.isData = !drainTick;
    end

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            drainLeft  <= '0;
            drainTimer <= '0;
            stage0     <= '0;
            stage1     <= '0;
            stage2     <= '0;
        end else begin
            if (inPacket && lineBit.eop) begin
                // One slot per bit time until all three stages are out
                drainLeft  <= 2'd3;
                drainTimer <= '0;
            end else if (drainLeft != 2'd0) begin
                drainTimer <= drainTick ? 4'd0 : drainTimer + 4'd1;
                if (drainTick)
                    drainLeft <= drainLeft - 2'd1;
            end
            if (pipeShift) begin
                stage0 <= newByte;
                stage1 <= stage0;
                stage2 <= stage1;
            end else if (inPacket && lineBit.eop) begin
                // Two newest bytes are CRC16 and not user data
                if (needCrc16) begin
                    stage0.isData <= 1'b0;
                    stage1.isData <= 1'b0;
                    stage2.isLast <= 1'b1;
                end else begin
                    stage0.isLast <= 1'b1;
                end
            end
        end
    end

    // ==================================================================
    // Backend handshake
    // ==================================================================
    always_ff @(posedge clk48) begin
        if (pipeShift && stage2.isData)
            rxData <= stage2.data;
    end

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            rxDataValid  <= 1'b0;
            rxIsLastByte <= 1'b0;
            lostByte     <= 1'b0;
        end else begin
            if (syncSeen)
                lostByte <= 1'b0;
            if (rxDataValid && rxAcceptNewData) begin
                rxDataValid  <= 1'b0;
                rxIsLastByte <= 1'b0;
            end
            if (pipeShift && stage2.isData) begin
                rxDataValid  <= 1'b1;
                rxIsLastByte <= stage2.isLast;
                // Unread byte gets overwritten
                if (rxDataValid && !rxAcceptNewData)
                    lostByte <= 1'b1;
            end
        end
    end

    assign keepPacket = !(dropPacket || lostByte);

    // Last byte flag never outlives the byte it belongs to
    assert property (@(posedge clk48) disable iff (rxRST)
        rxIsLastByte |-> rxDataValid)
        else $error("last byte flag without valid data");

endmodule

`default_nettype wire

// File: hw/usbRxTop.sv
`timescale 1ns/10ps
`default_nettype none

module usbRxTop (
    input  logic       clk48,
    input  logic       rxRST,
    input  logic       dataInP,
    input  logic       dataInN,
    input  logic       rxAcceptNewData,
    output logic [7:0] rxData,
    output logic       rxIsLastByte,
    output logic       rxDataValid,
    output logic       keepPacket
);

    sieLinePkg::rxBit lineBit;
    logic crcReset;
    logic useCrc16;
    logic crcValid;

    // Line sampling, bit recovery, NRZI and unstuffing
    rxLineFrontend frontend (
        .clk48   (clk48),
        .rxRST   (rxRST),
        .dataInP (dataInP),
        .dataInN (dataInN),
        .lineBit (lineBit)
    );

    // CRC5 and CRC16 over the unstuffed bits
    rxCrcCheck crcCheck (
        .clk48    (clk48),
        .rxRST    (rxRST),
        .lineBit  (lineBit),
        .crcReset (crcReset),
        .useCrc16 (useCrc16),
        .crcValid (crcValid)
    );

    // Packet controller and backend interface
    usbRx rxCtrl (
        .clk48           (clk48),
        .rxRST           (rxRST),
        .lineBit         (lineBit),
        .crcValid        (crcValid),
        .crcReset        (crcReset),
        .useCrc16        (useCrc16),
        .rxAcceptNewData (rxAcceptNewData),
        .rxData          (rxData),
        .rxIsLastByte    (rxIsLastByte),
        .rxDataValid     (rxDataValid),
        .keepPacket      (keepPacket)
    );

endmodule

`default_nettype wire

// File: verification/usbRxTb.sv
`timescale 1ns/10ps
`default_nettype none

module usbRxTb;

    // ======================================================================
    // Constants and DUT wiring
    // ======================================================================
    localparam int kindHandshake = 0;
    localparam int kindToken     = 1;
    localparam int kindData      = 2;
    localparam int faultNone     = 0;
    localparam int faultCrc      = 1;
    localparam int faultPid      = 2;
    localparam int faultStuff    = 3;
    localparam int faultHold     = 4;
    // Worst case packet covers sync, PID, payload, CRC16, stuffing, EOP and idle
    localparam int maxPayload    = 12;
    localparam int numPackets    = 9;
    localparam int bitsPerPacket = (32 + 8 * maxPayload) * 7 / 6 + 20;
    localparam int timeoutNs     = (numPackets * bitsPerPacket + 60) * 4 * 4;

    logic clk48;
    logic rxRST;
    logic dataInP;
    logic dataInN;
    logic rxAcceptNewData;
    logic [7:0] rxData;
    logic rxIsLastByte;
    logic rxDataValid;
    logic keepPacket;

    logic [7:0] payload[$];
    logic [7:0] expData[$];
    logic expLast[$];
    logic [7:0] gotData[$];
    logic gotLast[$];
    logic gotKeep;
    logic packetDone;

    usbRxTop dut (
        .clk48           (clk48),
        .rxRST           (rxRST),
        .dataInP         (dataInP),
        .dataInN         (dataInN),
        .rxAcceptNewData (rxAcceptNewData),
        .rxData          (rxData),
        .rxIsLastByte    (rxIsLastByte),
        .rxDataValid     (rxDataValid),
        .keepPacket      (keepPacket)
    );

    initial begin
        clk48 = 1'b0;
        forever #2 clk48 = ~clk48;
    end

    // ======================================================================
    // Reference model
    // ======================================================================

    // USB CRC16 over the payload with the LSB of each byte first
    function automatic logic [15:0] crc16Of(input int count);
        logic [15:0] c;
        logic fb;
        c = 16'hFFFF;
        for (int i = 0; i < count; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = payload[i][b] ^ c[15];
                c = {c[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
            end
        end
        return c;
    endfunction

    // USB CRC5 over the 11 bit address and endpoint field
    function automatic logic [4:0] crc5Of(input logic [10:0] field);
        logic [4:0] c;
        logic fb;
        c = 5'h1F;
        for (int i = 0; i < 11; i++) begin
            fb = field[i] ^ c[4];
            c = {c[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
        end
        return c;
    endfunction

    // Bytes the backend should read and the keep flag at the last one
    function automatic logic expectedBytes(input logic [7:0] pid, input int fault);
        expData.delete();
        expLast.delete();
        if (fault == faultHold) begin
            // Only the final byte survives when nothing is read
            expData.push_back(payload[payload.size() - 1]);
            expLast.push_back(1'b1);
        end else begin
            expData.push_back(pid);
            expLast.push_back(payload.size() == 0);
            foreach (payload[i]) begin
                expData.push_back(payload[i]);
                expLast.push_back(i == payload.size() - 1);
            end
        end
        return (fault == faultNone);
    endfunction

    // ======================================================================
    // Stimulus
    // ======================================================================

    // Token field; the CRC byte must not end in 000 or idle looks like sync
    task automatic makeToken();
        logic [10:0] field;
        logic [4:0] c;
        logic [15:0] word;
        do begin
            field = 11'($urandom);
            c = crc5Of(field);
        end while (c[2:0] == 3'b111);
        word = {~c[0], ~c[1], ~c[2], ~c[3], ~c[4], field};
        payload.delete();
        payload.push_back(word[7:0]);
        payload.push_back(word[15:8]);
    endtask

    // Random data payload, optionally starting with long runs of ones
    task automatic makeData(input int len, input logic withOnes);
        logic [15:0] c;
        do begin
            payload.delete();
            for (int i = 0; i < len; i++)
                payload.push_back(8'($urandom));
            if (withOnes) begin
                payload[0] = 8'hFF;
                payload[1] = 8'hFF;
            end
            c = crc16Of(len);
        end while (c[2:0] == 3'b111);
    endtask

    // One line state for a full bit time
    task automatic driveLine(input logic p, input logic n);
        dataInP = p;
        dataInN = n;
        repeat (4) begin
            @(posedge clk48);
            #1;
        end
    endtask

    task automatic sendPacket(input logic [7:0] pid, input int kind, input int fault);
        logic bits[$];
        logic lineBits[$];
        logic [15:0] c;
        logic level;
        int ones;
        logic injected;
        for (int i = 0; i < 7; i++)
            bits.push_back(1'b0);
        bits.push_back(1'b1);
        for (int b = 0; b < 8; b++)
            bits.push_back(pid[b]);
        foreach (payload[i])
            for (int b = 0; b < 8; b++)
                bits.push_back(payload[i][b]);
        if (kind == kindData) begin
            c = crc16Of(payload.size());
            for (int i = 15; i >= 0; i--)
                bits.push_back(~c[i] ^ (fault == faultCrc && i == 15));
        end
        // Bit stuffing; the fault sends an extra one ahead of the stuffed zero
        ones = 0;
        injected = 1'b0;
        foreach (bits[i]) begin
            lineBits.push_back(bits[i]);
            ones = bits[i] ? ones + 1 : 0;
            if (ones == 6) begin
                if (fault == faultStuff && !injected) begin
                    lineBits.push_back(1'b1);
                    injected = 1'b1;
                end
                lineBits.push_back(1'b0);
                ones = 0;
            end
        end
        if (fault == faultStuff && !injected)
            reportFailure("stuffing fault could not be placed in the packet");
        // A zero toggles the line in NRZI
        level = 1'b1;
        foreach (lineBits[i]) begin
            if (!lineBits[i])
                level = ~level;
            driveLine(level, ~level);
        end
        driveLine(1'b0, 1'b0);
        driveLine(1'b0, 1'b0);
        // Idle J long enough for the pipeline drain
        repeat (13)
            driveLine(1'b1, 1'b0);
    endtask

    // ======================================================================
    // Checking
    // ======================================================================
    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkByte(input int index, input usbPacketPkg::rxByte expected,
                             input usbPacketPkg::rxByte actual);
        if (expected.data !== actual.data)
            reportFailure($sformatf("[ERROR] t=%0t rxData[%0d] expected %02h actual %02h",
                                    $time, index, expected.data, actual.data));
        if (expected.isLast !== actual.isLast)
            reportFailure($sformatf("[ERROR] t=%0t rxIsLastByte[%0d] expected %0b actual %0b",
                                    $time, index, expected.isLast, actual.isLast));
    endtask

    task automatic checkKeep(input logic expected, input logic actual);
        if (expected !== actual)
            reportFailure($sformatf("[ERROR] t=%0t keepPacket expected %0b actual %0b",
                                    $time, expected, actual));
    endtask

    // Byte is taken on an edge where valid and accept are both high
    initial begin : collector
        forever begin
            @(negedge clk48);
            if (rxDataValid && rxAcceptNewData) begin
                gotData.push_back(rxData);
                gotLast.push_back(rxIsLastByte);
                if (rxIsLastByte) begin
                    gotKeep = keepPacket;
                    packetDone = 1'b1;
                end
            end
        end
    end

    // Send one packet and compare what the backend read
    task automatic runPacket(input logic [7:0] pid, input int kind, input int fault);
        logic keep;
        usbPacketPkg::rxByte expByte;
        usbPacketPkg::rxByte actByte;
        gotData.delete();
        gotLast.delete();
        packetDone = 1'b0;
        keep = expectedBytes(pid, fault);
        if (fault == faultHold)
            rxAcceptNewData = 1'b0;
        sendPacket(pid, kind, fault);
        rxAcceptNewData = 1'b1;
        wait (packetDone);
        if (gotData.size() != expData.size())
            reportFailure($sformatf("packet %02h delivered %0d bytes instead of %0d",
                                    pid, gotData.size(), expData.size()));
        foreach (expData[i]) begin
            expByte = {expData[i], expLast[i], 1'b1};
            actByte = {gotData[i], gotLast[i], 1'b1};
            checkByte(i, expByte, actByte);
        end
        checkKeep(keep, gotKeep);
        @(posedge clk48);
        #1;
    endtask

    // Ends a run that stops making progress
    initial begin : watchdog
        #(timeoutNs);
        $display("Timeout: the run hung waiting for a packet from the DUT");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h3456_e824));
        packetDone = 1'b0;
        gotKeep = 1'b0;
        rxRST = 1'b1;
        dataInP = 1'b1;
        dataInN = 1'b0;
        rxAcceptNewData = 1'b1;
        repeat (8) @(posedge clk48);
        #1;
        rxRST = 1'b0;
        repeat (20)
            driveLine(1'b1, 1'b0);

        // Handshake
        payload.delete();
        runPacket(8'hD2, kindHandshake, faultNone);
        // Data packets, random and with forced stuffing
        makeData(8, 1'b0);
        runPacket(8'hC3, kindData, faultNone);
        makeData(maxPayload, 1'b1);
        runPacket(8'hC3, kindData, faultNone);
        // Token with CRC5
        makeToken();
        runPacket(8'h69, kindToken, faultNone);
        // Corrupted CRC16 and PID check nibble
        makeData(5, 1'b0);
        runPacket(8'h4B, kindData, faultCrc);
        makeToken();
        runPacket(8'h79, kindToken, faultPid);
        // Seven ones in a row
        makeData(4, 1'b1);
        runPacket(8'hC3, kindData, faultStuff);
        // Backend stalls, then a clean packet
        makeData(6, 1'b0);
        runPacket(8'h4B, kindData, faultHold);
        makeData(3, 1'b0);
        runPacket(8'hC3, kindData, faultNone);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/sieLinePkg.sv
hw/usbPacketPkg.sv
hw/rxLineFrontend.sv
hw/rxCrcCheck.sv
hw/usbRx.sv
hw/usbRxTop.sv
verification/usbRxTb.sv

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module usbRxTb -Mdir obj_dir -o simv
out=$(./obj_dir/simv 2>&1 || true)
echo "$out"
if echo "$out" | grep -q "PASS: all tests"; then
    exit 0
fi
echo "FAIL: see errors above"
exit 1
